/* include/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// depth of the execute stage input buffer
`define DECODE_CREDITS 4

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0a
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct field of R-type
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

// ALU operation codes
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR  4'd3
`define ALU_XOR 4'd4
`define ALU_SLT 4'd5
`define ALU_SLL 4'd6
`define ALU_SRL 4'd7
`define ALU_LUI 4'd8

// branch types
`define BR_NONE 2'd0
`define BR_EQ   2'd1
`define BR_NE   2'd2

// operand source selects from the hazard unit
`define FWD_RF  2'd0
`define FWD_MEM 2'd1
`define FWD_WB  2'd2

`endif

/* src/decode_pkg.sv */
package decode_pkg;

	// data and address word
	typedef logic [31:0] word_t;

	// register file index
	typedef logic [4:0] regAddr_t;

	// instruction fields
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// ALU operation, values in decode_consts.svh
	typedef logic [3:0] aluFunc_t;

	// none, equal or not-equal
	typedef logic [1:0] branchType_t;

	// register file, memory stage or writeback stage
	typedef logic [1:0] forwardSel_t;

	// enough for the full execute buffer depth
	typedef logic [2:0] credit_t;

endpackage

/* src/instrDecoder.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module instrDecoder import decode_pkg::*; (
	input  word_t       instr,
	output aluFunc_t    aluFunc,
	output logic        regWrite,
	output logic        memRead,
	output logic        memWrite,
	output logic        useImm,
	output regAddr_t    destReg,
	output word_t       extImm,
	output logic [4:0]  shamt,
	output branchType_t branchType,
	output logic        jump,
	output logic        jumpReg,
	output logic        link,
	output logic        reserved
);
	opcode_t opcode;
	funct_t funct;
	regAddr_t rt;
	regAddr_t rd;
	logic [15:0] imm;
	logic zeroExt;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm = instr[15:0];
	assign shamt = instr[10:6];

	// logical immediates are zero extended, the rest sign extended
	assign extImm = zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};

	always_comb begin
		aluFunc = `ALU_ADD;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		useImm = 1'b0;
		destReg = '0;
		zeroExt = 1'b0;
		branchType = `BR_NONE;
		jump = 1'b0;
		jumpReg = 1'b0;
		link = 1'b0;
		reserved = 1'b0;
		case (opcode)
			`OP_RTYPE: begin
				regWrite = 1'b1;
				destReg = rd;
				case (funct)
					`FN_ADDU: aluFunc = `ALU_ADD;
					`FN_SUBU: aluFunc = `ALU_SUB;
					`FN_AND:  aluFunc = `ALU_AND;
					`FN_OR:   aluFunc = `ALU_OR;
					`FN_XOR:  aluFunc = `ALU_XOR;
					`FN_SLT:  aluFunc = `ALU_SLT;
					`FN_SLL:  aluFunc = `ALU_SLL;
					`FN_SRL:  aluFunc = `ALU_SRL;
					`FN_JR: begin
						regWrite = 1'b0;
						destReg = '0;
						jumpReg = 1'b1;
					end
					default: begin
						regWrite = 1'b0;
						destReg = '0;
						reserved = 1'b1;
					end
				endcase
			end
			`OP_ADDIU: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				destReg = rt;
			end
			`OP_SLTI: begin
				aluFunc = `ALU_SLT;
				regWrite = 1'b1;
				useImm = 1'b1;
				destReg = rt;
			end
			`OP_ANDI: begin
				aluFunc = `ALU_AND;
				regWrite = 1'b1;
				useImm = 1'b1;
				zeroExt = 1'b1;
				destReg = rt;
			end
			`OP_ORI: begin
				aluFunc = `ALU_OR;
				regWrite = 1'b1;
				useImm = 1'b1;
				zeroExt = 1'b1;
				destReg = rt;
			end
			`OP_LUI: begin
				aluFunc = `ALU_LUI;
				regWrite = 1'b1;
				useImm = 1'b1;
				zeroExt = 1'b1;
				destReg = rt;
			end
			`OP_LW: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				useImm = 1'b1;
				destReg = rt;
			end
			// address add only, no register result
			`OP_SW: begin
				memWrite = 1'b1;
				useImm = 1'b1;
			end
			`OP_BEQ: begin
				aluFunc = `ALU_SUB;
				branchType = `BR_EQ;
			end
			`OP_BNE: begin
				aluFunc = `ALU_SUB;
				branchType = `BR_NE;
			end
			`OP_J: jump = 1'b1;
			// return address goes to r31
			`OP_JAL: begin
				jump = 1'b1;
				link = 1'b1;
				regWrite = 1'b1;
				destReg = 5'd31;
			end
			default: reserved = 1'b1;
		endcase
	end

endmodule

/* src/branchResolver.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module branchResolver import decode_pkg::*; (
	input  word_t       pcPlus4,
	input  word_t       instr,
	input  word_t       extImm,
	input  word_t       srcA,
	input  word_t       srcB,
	input  branchType_t branchType,
	input  logic        jump,
	input  logic        jumpReg,
	input  logic        accept,
	output logic        redirectValid,
	output word_t       redirectPc
);
	logic operandsEqual;
	logic branchTaken;
	word_t branchTarget;
	word_t jumpTarget;

	// compare on forwarded values so a branch sees results still in flight
	assign operandsEqual = (srcA == srcB);

	always_comb begin
		case (branchType)
			`BR_EQ:  branchTaken = operandsEqual;
			`BR_NE:  branchTaken = !operandsEqual;
			default: branchTaken = 1'b0;
		endcase
	end

	// word offset relative to the delay slot
	assign branchTarget = pcPlus4 + {extImm[29:0], 2'b00};

	// pseudo-direct, stays in the current 256 MB region
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

	always_comb begin
		if (jumpReg) begin
			redirectPc = srcA;
		end else if (jump) begin
			redirectPc = jumpTarget;
		end else begin
			redirectPc = branchTarget;
		end
	end

	assign redirectValid = accept && (branchTaken || jump || jumpReg);

endmodule

/* src/operandFetch.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module operandFetch import decode_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  regAddr_t    rsAddr,
	input  regAddr_t    rtAddr,
	input  logic        wbEnable,
	input  regAddr_t    wbAddr,
	input  word_t       wbData,
	input  forwardSel_t forwardA,
	input  forwardSel_t forwardB,
	input  word_t       aluOutM,
	input  word_t       resultW,
	output word_t       srcA,
	output word_t       srcB
);
	word_t regFile [32];
	word_t rfA;
	word_t rfB;

	// register 0 is never written, so it reads zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbEnable && wbAddr != 5'd0) begin
			regFile[wbAddr] <= wbData;
		end
	end

	// same-cycle writeback wins over the stored value
	function automatic word_t readReg(input regAddr_t addr);
		if (addr == 5'd0) begin
			return '0;
		end else if (wbEnable && wbAddr == addr) begin
			return wbData;
		end
		return regFile[addr];
	endfunction

	function automatic word_t pickSource(input forwardSel_t sel, input word_t rfValue);
		case (sel)
			`FWD_MEM: return aluOutM;
			`FWD_WB:  return resultW;
			default:  return rfValue;
		endcase
	endfunction

	always_comb begin
		rfA = readReg(rsAddr);
		rfB = readReg(rtAddr);
		srcA = pickSource(forwardA, rfA);
		srcB = pickSource(forwardB, rfB);
	end

endmodule

/* src/decodeQueue.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module decodeQueue import decode_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       instrValid,
	input  logic       creditReturn,
	output logic       fetchReady,
	input  aluFunc_t   aluFunc,
	input  logic       regWrite,
	input  logic       memRead,
	input  logic       memWrite,
	input  logic       useImm,
	input  regAddr_t   destReg,
	input  word_t      extImm,
	input  logic [4:0] shamt,
	input  logic       link,
	input  logic       reserved,
	input  word_t      srcA,
	input  word_t      srcB,
	input  word_t      pcPlus4,
	output logic       decValid,
	output aluFunc_t   decAluFunc,
	output logic       decRegWrite,
	output logic       decMemRead,
	output logic       decMemWrite,
	output logic       decUseImm,
	output regAddr_t   decDestReg,
	output word_t      decExtImm,
	output logic [4:0] decShamt,
	output logic       decLink,
	output logic       decReserved,
	output word_t      decSrcA,
	output word_t      decSrcB,
	output word_t      decPcPlus4
);
	credit_t creditCount;
	logic accept;
	logic refund;

	assign fetchReady = (creditCount != '0);
	assign accept = instrValid && fetchReady;

	// a return while already full is dropped so the count stays bounded
	assign refund = creditReturn && (accept || creditCount < credit_t'(`DECODE_CREDITS));

	always_ff @(posedge clk) begin
		if (reset) begin
			creditCount <= credit_t'(`DECODE_CREDITS);
			decValid <= 1'b0;
		end else begin
			creditCount <= creditCount - credit_t'(accept) + credit_t'(refund);
			decValid <= accept;
		end
	end

	// bundle holds until the next acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			decAluFunc <= aluFunc;
			decRegWrite <= regWrite;
			decMemRead <= memRead;
			decMemWrite <= memWrite;
			decUseImm <= useImm;
			decDestReg <= destReg;
			decExtImm <= extImm;
			decShamt <= shamt;
			decLink <= link;
			decReserved <= reserved;
			decSrcA <= srcA;
			decSrcB <= srcB;
			decPcPlus4 <= pcPlus4;
		end
	end

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import decode_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        instrValid,
	input  word_t       instr,
	input  word_t       pcPlus4,
	output logic        fetchReady,
	output logic        redirectValid,
	output word_t       redirectPc,
	input  forwardSel_t forwardA,
	input  forwardSel_t forwardB,
	input  word_t       aluOutM,
	input  word_t       resultW,
	input  logic        wbEnable,
	input  regAddr_t    wbAddr,
	input  word_t       wbData,
	input  logic        creditReturn,
	output logic        decValid,
	output aluFunc_t    decAluFunc,
	output logic        decRegWrite,
	output logic        decMemRead,
	output logic        decMemWrite,
	output logic        decUseImm,
	output regAddr_t    decDestReg,
	output word_t       decExtImm,
	output logic [4:0]  decShamt,
	output logic        decLink,
	output logic        decReserved,
	output word_t       decSrcA,
	output word_t       decSrcB,
	output word_t       decPcPlus4
);
	aluFunc_t aluFunc;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic useImm;
	regAddr_t destReg;
	word_t extImm;
	logic [4:0] shamt;
	branchType_t branchType;
	logic jump;
	logic jumpReg;
	logic link;
	logic reserved;
	regAddr_t rsAddr;
	regAddr_t rtAddr;
	word_t srcA;
	word_t srcB;
	logic accept;

	assign rsAddr = instr[25:21];
	assign rtAddr = instr[20:16];
	assign accept = instrValid && fetchReady;

	instrDecoder instrDecoder_i (
		.instr(instr), .aluFunc(aluFunc), .regWrite(regWrite), .memRead(memRead),
		.memWrite(memWrite), .useImm(useImm), .destReg(destReg), .extImm(extImm),
		.shamt(shamt), .branchType(branchType), .jump(jump), .jumpReg(jumpReg),
		.link(link), .reserved(reserved)
	);

	operandFetch operandFetch_i (
		.clk(clk), .reset(reset), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.wbEnable(wbEnable), .wbAddr(wbAddr), .wbData(wbData),
		.forwardA(forwardA), .forwardB(forwardB), .aluOutM(aluOutM),
		.resultW(resultW), .srcA(srcA), .srcB(srcB)
	);

	// redirect is resolved here, in the acceptance cycle
	branchResolver branchResolver_i (
		.pcPlus4(pcPlus4), .instr(instr), .extImm(extImm), .srcA(srcA), .srcB(srcB),
		.branchType(branchType), .jump(jump), .jumpReg(jumpReg), .accept(accept),
		.redirectValid(redirectValid), .redirectPc(redirectPc)
	);

	decodeQueue decodeQueue_i (
		.clk(clk), .reset(reset), .instrValid(instrValid), .creditReturn(creditReturn),
		.fetchReady(fetchReady), .aluFunc(aluFunc), .regWrite(regWrite),
		.memRead(memRead), .memWrite(memWrite), .useImm(useImm), .destReg(destReg),
		.extImm(extImm), .shamt(shamt), .link(link), .reserved(reserved),
		.srcA(srcA), .srcB(srcB), .pcPlus4(pcPlus4), .decValid(decValid),
		.decAluFunc(decAluFunc), .decRegWrite(decRegWrite), .decMemRead(decMemRead),
		.decMemWrite(decMemWrite), .decUseImm(decUseImm), .decDestReg(decDestReg),
		.decExtImm(decExtImm), .decShamt(decShamt), .decLink(decLink),
		.decReserved(decReserved), .decSrcA(decSrcA), .decSrcB(decSrcB),
		.decPcPlus4(decPcPlus4)
	);

endmodule

/* sim/decodeStage_asserts.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module decodeStage_asserts import decode_pkg::*; (
	input logic    clk,
	input logic    reset,
	input credit_t creditCount,
	input logic    instrValid,
	input logic    creditReturn,
	input logic    fetchReady,
	input logic    decValid
);
	logic accept;

	assign accept = instrValid && fetchReady;

	creditBound: assert property (@(posedge clk) disable iff (reset)
		creditCount <= credit_t'(`DECODE_CREDITS))
		else $error("credit count above execute buffer depth");

	validAfterAccept: assert property (@(posedge clk) disable iff (reset)
		accept |=> decValid)
		else $error("decValid missing one cycle after acceptance");

	validOnlyAfterAccept: assert property (@(posedge clk) disable iff (reset)
		decValid |-> $past(accept))
		else $error("decValid without acceptance in the previous cycle");

	// out of credits with nothing returned, fetch stays stalled
	readyLowWhenEmpty: assert property (@(posedge clk) disable iff (reset)
		creditCount == '0 && !creditReturn |=> !fetchReady)
		else $error("fetchReady rose with zero credits and no credit returned");

endmodule

bind decodeQueue decodeStage_asserts decodeStage_asserts_i (
	.clk(clk), .reset(reset), .creditCount(creditCount),
	.instrValid(instrValid), .creditReturn(creditReturn),
	.fetchReady(fetchReady), .decValid(decValid)
);

/* sim/decodeStage_tb.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module decodeStage_tb import decode_pkg::*; ();
	localparam int NUM_RANDOM = 240;
	localparam int NUM_TESTS = NUM_RANDOM + 9;
	localparam int TIMEOUT_CYCLES = 40 * NUM_TESTS + 100;

	typedef struct packed {
		aluFunc_t    aluFunc;
		logic        regWrite;
		logic        memRead;
		logic        memWrite;
		logic        useImm;
		regAddr_t    destReg;
		word_t       extImm;
		logic [4:0]  shamt;
		logic        link;
		logic        reserved;
		branchType_t branchType;
		logic        jump;
		logic        jumpReg;
		word_t       srcA;
		word_t       srcB;
		word_t       pcPlus4;
	} expected_t;

	logic clk;
	logic reset;
	logic instrValid;
	word_t instr;
	word_t pcPlus4;
	logic fetchReady;
	logic redirectValid;
	word_t redirectPc;
	forwardSel_t forwardA;
	forwardSel_t forwardB;
	word_t aluOutM;
	word_t resultW;
	logic wbEnable;
	regAddr_t wbAddr;
	word_t wbData;
	logic creditReturn;
	logic decValid;
	aluFunc_t decAluFunc;
	logic decRegWrite;
	logic decMemRead;
	logic decMemWrite;
	logic decUseImm;
	regAddr_t decDestReg;
	word_t decExtImm;
	logic [4:0] decShamt;
	logic decLink;
	logic decReserved;
	word_t decSrcA;
	word_t decSrcB;
	word_t decPcPlus4;

	word_t shadowRegs [32];
	expected_t expQ [$];
	expected_t head;
	int issuedCount;
	int returnedCount;
	int cycleCount;
	logic holdCredits;

	decodeStage decodeStage_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			reportFailure("word mismatch");
		end
	endtask

	task automatic checkReg(input string name, input regAddr_t exp, input regAddr_t act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			reportFailure("register index mismatch");
		end
	endtask

	task automatic checkAlu(input string name, input aluFunc_t exp, input aluFunc_t act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			reportFailure("ALU code mismatch");
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
			reportFailure("control bit mismatch");
		end
	endtask

	// decode fields from the ISA encoding of the subset
	function automatic expected_t decodeRef(input word_t w);
		expected_t e;
		opcode_t op;
		funct_t fn;
		op = w[31:26];
		fn = w[5:0];
		e = '0;
		e.shamt = w[10:6];
		e.extImm = {{16{w[15]}}, w[15:0]};
		if (op == `OP_ANDI || op == `OP_ORI || op == `OP_LUI)
			e.extImm = {16'b0, w[15:0]};
		case (op)
			`OP_RTYPE: begin
				e.regWrite = 1'b1;
				e.destReg = w[15:11];
				case (fn)
					`FN_ADDU: e.aluFunc = `ALU_ADD;
					`FN_SUBU: e.aluFunc = `ALU_SUB;
					`FN_AND:  e.aluFunc = `ALU_AND;
					`FN_OR:   e.aluFunc = `ALU_OR;
					`FN_XOR:  e.aluFunc = `ALU_XOR;
					`FN_SLT:  e.aluFunc = `ALU_SLT;
					`FN_SLL:  e.aluFunc = `ALU_SLL;
					`FN_SRL:  e.aluFunc = `ALU_SRL;
					`FN_JR: begin
						e.regWrite = 1'b0;
						e.jumpReg = 1'b1;
					end
					default: begin
						e.regWrite = 1'b0;
						e.reserved = 1'b1;
					end
				endcase
			end
			`OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI, `OP_LW: begin
				e.regWrite = 1'b1;
				e.useImm = 1'b1;
				e.destReg = w[20:16];
				e.memRead = (op == `OP_LW);
				e.aluFunc = (op == `OP_SLTI) ? `ALU_SLT : (op == `OP_ANDI) ? `ALU_AND :
					(op == `OP_ORI) ? `ALU_OR : (op == `OP_LUI) ? `ALU_LUI : `ALU_ADD;
			end
			`OP_SW: begin
				e.memWrite = 1'b1;
				e.useImm = 1'b1;
			end
			`OP_BEQ: e.branchType = `BR_EQ;
			`OP_BNE: e.branchType = `BR_NE;
			`OP_J:   e.jump = 1'b1;
			`OP_JAL: begin
				e.jump = 1'b1;
				e.link = 1'b1;
				e.regWrite = 1'b1;
				e.destReg = 5'd31;
			end
			default: e.reserved = 1'b1;
		endcase
		return e;
	endfunction

	function automatic word_t operandRef(input regAddr_t addr, input forwardSel_t sel);
		if (sel == `FWD_MEM)
			return aluOutM;
		if (sel == `FWD_WB)
			return resultW;
		if (addr == 5'd0)
			return '0;
		if (wbEnable && wbAddr == addr)
			return wbData;
		return shadowRegs[addr];
	endfunction

	// random fields, with rt copied from rs half the time so branches get taken
	function automatic word_t makeInstr(input int kind);
		word_t w;
		funct_t fnList [9] = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR,
			`FN_SLT, `FN_SLL, `FN_SRL, `FN_JR};
		opcode_t opList [11] = '{`OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_LUI, `OP_SLTI,
			`OP_LW, `OP_SW, `OP_BEQ, `OP_BNE, `OP_J, `OP_JAL};
		w = $urandom;
		if (kind < 9) begin
			w[31:26] = `OP_RTYPE;
			w[5:0] = fnList[kind];
		end else begin
			w[31:26] = opList[kind - 9];
		end
		if ($urandom % 2)
			w[20:16] = w[25:21];
		return w;
	endfunction

	function automatic forwardSel_t pickForward();
		int r;
		r = $urandom % 4;
		return (r == 3) ? `FWD_RF : forwardSel_t'(r);
	endfunction

	task automatic applyWriteback();
		if (wbEnable && wbAddr != 5'd0)
			shadowRegs[wbAddr] = wbData;
	endtask

	task automatic issueOne(input word_t word);
		expected_t e;
		logic taken;
		instr = word;
		pcPlus4 = $urandom & 32'hffff_fffc;
		forwardA = pickForward();
		forwardB = pickForward();
		if (word[25:21] == word[20:16] && ($urandom % 2))
			forwardB = forwardA;
		aluOutM = $urandom;
		resultW = $urandom;
		wbEnable = 1'($urandom % 2);
		wbAddr = regAddr_t'($urandom);
		wbData = $urandom;
		instrValid = 1'b1;
		#1;
		while (!fetchReady) begin
			applyWriteback();
			@(posedge clk);
			#5;
		end
		e = decodeRef(word);
		e.srcA = operandRef(word[25:21], forwardA);
		e.srcB = operandRef(word[20:16], forwardB);
		e.pcPlus4 = pcPlus4;
		taken = e.jump || e.jumpReg || (e.branchType == `BR_EQ && e.srcA == e.srcB) ||
			(e.branchType == `BR_NE && e.srcA != e.srcB);
		checkBit("redirectValid", taken, redirectValid);
		if (taken && e.jumpReg)
			checkWord("redirectPc jr", e.srcA, redirectPc);
		else if (taken && e.jump)
			checkWord("redirectPc jump",
				(pcPlus4 & 32'hf000_0000) | {4'h0, word[25:0], 2'b00}, redirectPc);
		else if (taken)
			checkWord("redirectPc branch",
				pcPlus4 + ({{16{word[15]}}, word[15:0]} << 2), redirectPc);
		expQ.push_back(e);
		applyWriteback();
		@(posedge clk);
		#5;
		instrValid = 1'b0;
		wbEnable = 1'b0;
	endtask

	task automatic compareItem();
		if (expQ.size() == 0)
			reportFailure("decValid seen with no accepted instruction pending");
		head = expQ.pop_front();
		issuedCount++;
		if (issuedCount - returnedCount > `DECODE_CREDITS)
			reportFailure("more items in flight than the execute buffer holds");
		checkBit("regWrite", head.regWrite, decRegWrite);
		checkBit("memRead", head.memRead, decMemRead);
		checkBit("memWrite", head.memWrite, decMemWrite);
		checkBit("link", head.link, decLink);
		checkBit("reserved", head.reserved, decReserved);
		checkReg("shamt", head.shamt, decShamt);
		if ((head.regWrite && !head.link) || head.memWrite)
			checkAlu("aluFunc", head.aluFunc, decAluFunc);
		if (head.regWrite)
			checkReg("destReg", head.destReg, decDestReg);
		checkBit("useImm", head.useImm, decUseImm);
		checkWord("extImm", head.extImm, decExtImm);
		checkWord("srcA", head.srcA, decSrcA);
		checkWord("srcB", head.srcB, decSrcB);
		checkWord("pcPlus4", head.pcPlus4, decPcPlus4);
	endtask

	always @(negedge clk) begin
		if (!reset && decValid)
			compareItem();
	end

	// execute side frees items after random delays
	initial begin
		creditReturn = 1'b0;
		forever begin
			@(posedge clk);
			#5;
			creditReturn = 1'b0;
			if (!reset && !holdCredits && issuedCount > returnedCount && ($urandom % 3 == 0)) begin
				creditReturn = 1'b1;
				returnedCount++;
			end
		end
	end

	initial begin
		cycleCount = 0;
		forever begin
			@(posedge clk);
			cycleCount++;
			if (cycleCount > TIMEOUT_CYCLES) begin
				$display("timeout, the run did not finish in %0d cycles", TIMEOUT_CYCLES);
				reportFailure("stopping on timeout");
			end
		end
	end

	initial begin
		word_t w;
		expected_t probe;
		void'($urandom(33));
		issuedCount = 0;
		returnedCount = 0;
		holdCredits = 1'b0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pcPlus4 = '0;
		forwardA = `FWD_RF;
		forwardB = `FWD_RF;
		aluOutM = '0;
		resultW = '0;
		wbEnable = 1'b0;
		wbAddr = '0;
		wbData = '0;
		for (int i = 0; i < 32; i++)
			shadowRegs[i] = '0;
		repeat (4) @(posedge clk);
		#5;
		reset = 1'b0;
		#1;
		checkBit("fetchReady after reset", 1'b1, fetchReady);
		checkBit("decValid after reset", 1'b0, decValid);
		for (int n = 0; n < NUM_RANDOM; n++) begin
			if ($urandom % 7 == 0) begin
				do begin
					w = $urandom;
					probe = decodeRef(w);
				end while (!probe.reserved);
			end else begin
				w = makeInstr($urandom % 20);
			end
			issueOne(w);
		end
		// drain execute, then stall it and fill all credits
		while (issuedCount != returnedCount || expQ.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#5;
		holdCredits = 1'b1;
		for (int n = 0; n < 4; n++)
			issueOne(makeInstr($urandom % 20));
		#1;
		checkBit("fetchReady with no credits", 1'b0, fetchReady);
		checkBit("redirectValid while idle", 1'b0, redirectValid);
		fork
			begin
				repeat (10) @(posedge clk);
				holdCredits = 1'b0;
			end
			for (int n = 0; n < 5; n++)
				issueOne(makeInstr($urandom % 20));
		join
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
src/decode_pkg.sv
src/instrDecoder.sv
src/branchResolver.sv
src/operandFetch.sv
src/decodeQueue.sv
src/decodeStage.sv
sim/decodeStage_asserts.sv
sim/decodeStage_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module decodeStage_tb \
	-o simv > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1

grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" && exit 0 || {
	echo "simulation failed, see sim.log"
	exit 1
}
